// File: Makefile
# Verilator build and run of the output queue testbench

SHELL   := /bin/bash
SIM_LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/Voutput_queues_tb: sim.f $(wildcard src/*.sv tb/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module output_queues_tb

run: obj_dir/Voutput_queues_tb
	set -o pipefail; ./obj_dir/Voutput_queues_tb | tee $(SIM_LOG)
	@if grep -q "Testbench failed" $(SIM_LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module output_queues_tb

clean:
	rm -rf obj_dir $(SIM_LOG)

// File: sim.f
src/oq_pkg.sv
src/fallthrough_fifo.sv
src/oq_write_ctrl.sv
src/oq_output_port.sv
src/output_queues.sv
tb/tb_clock_gen.sv
tb/output_queues_properties.sv
tb/output_queues_tb.sv

// File: src/fallthrough_fifo.sv
// First-word-fall-through FIFO with a payload type parameter and a nearly-full flag

`timescale 1ns/1ps

module fallthrough_fifo #(
   parameter type payload_t  = logic [7:0],
   parameter int  DEPTH_BITS = 4,
   // Free slots below which nearly_full is raised
   parameter int  NF_THRESH  = 2
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,

   input  payload_t din,
   input  logic     wr_en,
   input  logic     rd_en,

   output payload_t dout,
   output logic     empty,
   output logic     nearly_full
);

   localparam int DEPTH = 2 ** DEPTH_BITS;
   localparam logic [DEPTH_BITS:0] DEPTH_CNT  = (DEPTH_BITS + 1)'(DEPTH);
   localparam logic [DEPTH_BITS:0] THRESH_CNT = (DEPTH_BITS + 1)'(NF_THRESH);

   payload_t              mem [DEPTH];
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS:0]   count;
   logic [DEPTH_BITS:0]   free_slots;
   logic                  full;
   logic                  wr_ok;
   logic                  rd_ok;

   ////////////////////
   // Status
   ////////////////////

   assign full        = (count == DEPTH_CNT);
   assign empty       = (count == '0);
   assign free_slots  = DEPTH_CNT - count;
   assign nearly_full = (free_slots < THRESH_CNT);

   // Writes into a full buffer are ignored
   assign wr_ok = wr_en & ~full;
   assign rd_ok = rd_en & ~empty;

   // Head entry always visible
   assign dout = mem[rd_ptr];

   ////////////////////
   // Storage
   ////////////////////

   always_ff @(posedge axi_aclk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= din;
      end
   end

   ////////////////////
   // Pointers and occupancy
   ////////////////////

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: src/oq_output_port.sv
// One output queue: data FIFO, metadata FIFO and read-side metadata sequencer

`timescale 1ns/1ps

module oq_output_port import oq_pkg::*; (
   input  logic       axi_aclk,
   input  logic       axi_resetn,

   // Write side
   input  axis_word_t wr_word,
   input  user_t      wr_user,
   input  logic       wr_en,
   input  logic       meta_wr_en,
   output logic       room,

   // Output stream
   output axis_word_t m_axis_word,
   output user_t      m_axis_tuser,
   output logic       m_axis_tvalid,
   input  logic       m_axis_tready
);

   typedef enum logic {
      WAIT_HEADER,
      WAIT_EOP
   } seq_t;

   seq_t       seq;
   axis_word_t data_dout;
   user_t      meta_dout;
   user_t      held_user;
   logic       data_empty;
   logic       data_nearly_full;
   logic       meta_nearly_full;
   logic       rd_en;
   logic       meta_rd_en;

   fallthrough_fifo #(
      .payload_t  (axis_word_t),
      .DEPTH_BITS (DATA_DEPTH_BITS),
      .NF_THRESH  (MAX_PKT_WORDS)
   ) i_data_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (wr_word),
      .wr_en       (wr_en),
      .rd_en       (rd_en),
      .dout        (data_dout),
      .empty       (data_empty),
      .nearly_full (data_nearly_full)
   );

   // Empty flag unused, each entry has its words in the data FIFO
   fallthrough_fifo #(
      .payload_t  (user_t),
      .DEPTH_BITS (META_DEPTH_BITS),
      .NF_THRESH  (2)
   ) i_meta_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .din         (wr_user),
      .wr_en       (meta_wr_en),
      .rd_en       (meta_rd_en),
      .dout        (meta_dout),
      .empty       (),
      .nearly_full (meta_nearly_full)
   );

   assign room          = ~(data_nearly_full | meta_nearly_full);
   assign m_axis_tvalid = ~data_empty;
   assign m_axis_word   = data_dout;
   assign rd_en         = m_axis_tready & ~data_empty;

   ////////////////////
   // Metadata sequencer
   ////////////////////

   // Pop on the first beat, then show the saved copy until tlast
   assign meta_rd_en   = (seq == WAIT_HEADER) & rd_en;
   assign m_axis_tuser = (seq == WAIT_HEADER) ? meta_dout : held_user;

   always_ff @(posedge axi_aclk) begin
      if (meta_rd_en) begin
         held_user <= meta_dout;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         seq <= WAIT_HEADER;
      end else begin
         case (seq)
            WAIT_HEADER: begin
               // Single-beat packets stay here
               if (rd_en && !data_dout.tlast) begin
                  seq <= WAIT_EOP;
               end
            end
            WAIT_EOP: begin
               if (rd_en && data_dout.tlast) begin
                  seq <= WAIT_HEADER;
               end
            end
            default: seq <= WAIT_HEADER;
         endcase
      end
   end

endmodule

// File: src/oq_pkg.sv
// Output queue widths, depths, queue count and the stream word and metadata types

package oq_pkg;

   ////////////////////
   // Sizes
   ////////////////////

   // Four unicast ports plus the shared CPU queue
   localparam int NUM_QUEUES = 5;

   localparam int DATA_WIDTH = 32;
   localparam int STRB_WIDTH = DATA_WIDTH / 8;
   localparam int USER_WIDTH = 32;

   // Lowest destination bit inside tuser
   localparam int DST_POS = 24;

   // Data FIFO holds 16 words, metadata FIFO holds 4 entries
   localparam int DATA_DEPTH_BITS = 4;
   localparam int META_DEPTH_BITS = 2;

   // Longest legal packet in beats
   localparam int MAX_PKT_WORDS = 8;

   ////////////////////
   // Types
   ////////////////////

   // One beat of the stream without its handshake
   typedef struct packed {
      logic [DATA_WIDTH-1:0] tdata;
      logic [STRB_WIDTH-1:0] tstrb;
      logic                  tlast;
   } axis_word_t;

   // Packet metadata, carried with the first beat
   typedef logic [USER_WIDTH-1:0] user_t;

   // One bit per output queue
   typedef logic [NUM_QUEUES-1:0] queue_mask_t;

endpackage

// File: src/oq_write_ctrl.sv
// Output queue writer: destination decode, accept or drop decision, queue write enables

`timescale 1ns/1ps

module oq_write_ctrl import oq_pkg::*; (
   input  logic        axi_aclk,
   input  logic        axi_resetn,

   // Input stream
   input  axis_word_t  s_axis_word,
   input  user_t       s_axis_tuser,
   input  logic        s_axis_tvalid,
   output logic        s_axis_tready,

   // Room flags from the queues
   input  queue_mask_t room,

   // Write side of all queues
   output axis_word_t  wr_word,
   output user_t       wr_user,
   output queue_mask_t wr_en,
   output queue_mask_t meta_wr_en
);

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      DROP
   } state_t;

   state_t      state;
   queue_mask_t dst;
   queue_mask_t dst_q;
   queue_mask_t room_q;
   logic        first_word;
   logic        xfer;

   ////////////////////
   // Destination decode
   ////////////////////

   // Even bits pick queues 0 to 3, any odd bit picks the CPU queue
   always_comb begin
      dst = '0;
      for (int i = 0; i < NUM_QUEUES - 1; i++) begin
         dst[i] = s_axis_tuser[DST_POS + 2*i];
      end
      for (int i = 0; i < NUM_QUEUES - 1; i++) begin
         dst[NUM_QUEUES-1] = dst[NUM_QUEUES-1] | s_axis_tuser[DST_POS + 2*i + 1];
      end
   end

   // Room sampled one cycle before the decision
   always_ff @(posedge axi_aclk) begin
      room_q <= room;
   end

   ////////////////////
   // Packet FSM
   ////////////////////

   assign s_axis_tready = (state != IDLE);
   assign xfer          = s_axis_tvalid & s_axis_tready;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state      <= IDLE;
         dst_q      <= '0;
         first_word <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (s_axis_tvalid) begin
                  dst_q      <= dst;
                  first_word <= 1'b1;
                  // An empty mask passes here and is written nowhere
                  if ((dst & ~room_q) == '0) begin
                     state <= WRITE;
                  end else begin
                     state <= DROP;
                  end
               end
            end
            WRITE: begin
               if (xfer) begin
                  first_word <= 1'b0;
                  if (s_axis_word.tlast) begin
                     state <= IDLE;
                  end
               end
            end
            DROP: begin
               if (xfer && s_axis_word.tlast) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Queue write side
   ////////////////////

   assign wr_word    = s_axis_word;
   assign wr_user    = s_axis_tuser;
   assign wr_en      = (state == WRITE && xfer) ? dst_q : '0;
   assign meta_wr_en = first_word ? wr_en : '0;

endmodule

// File: src/output_queues.sv
// Output queue stage top level: write controller and the five output ports

`timescale 1ns/1ps

module output_queues import oq_pkg::*; (
   input  logic        axi_aclk,
   input  logic        axi_resetn,

   // Input stream
   input  axis_word_t  s_axis_word,
   input  user_t       s_axis_tuser,
   input  logic        s_axis_tvalid,
   output logic        s_axis_tready,

   // Output streams, one per queue
   output axis_word_t  m_axis_word  [NUM_QUEUES],
   output user_t       m_axis_tuser [NUM_QUEUES],
   output queue_mask_t m_axis_tvalid,
   input  queue_mask_t m_axis_tready
);

   axis_word_t  wr_word;
   user_t       wr_user;
   queue_mask_t wr_en;
   queue_mask_t meta_wr_en;
   queue_mask_t room;

   oq_write_ctrl i_oq_write_ctrl (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_word   (s_axis_word),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .room          (room),
      .wr_word       (wr_word),
      .wr_user       (wr_user),
      .wr_en         (wr_en),
      .meta_wr_en    (meta_wr_en)
   );

   ////////////////////
   // Queues
   ////////////////////

   for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_port
      oq_output_port i_oq_output_port (
         .axi_aclk      (axi_aclk),
         .axi_resetn    (axi_resetn),
         .wr_word       (wr_word),
         .wr_user       (wr_user),
         .wr_en         (wr_en[i]),
         .meta_wr_en    (meta_wr_en[i]),
         .room          (room[i]),
         .m_axis_word   (m_axis_word[i]),
         .m_axis_tuser  (m_axis_tuser[i]),
         .m_axis_tvalid (m_axis_tvalid[i]),
         .m_axis_tready (m_axis_tready[i])
      );
   end

endmodule

// File: tb/output_queues_properties.sv
// Concurrent assertions on the output queue top level and their bind

`timescale 1ns/1ps

module output_queues_properties import oq_pkg::*; (
   input logic        axi_aclk,
   input logic        axi_resetn,
   input axis_word_t  s_axis_word,
   input logic        s_axis_tvalid,
   input logic        s_axis_tready,
   input axis_word_t  m_axis_word  [NUM_QUEUES],
   input user_t       m_axis_tuser [NUM_QUEUES],
   input queue_mask_t m_axis_tvalid,
   input queue_mask_t m_axis_tready
);

   // One idle cycle after every packet
   a_idle_after_last: assert property (
      @(posedge axi_aclk) disable iff (!axi_resetn)
      s_axis_tvalid && s_axis_tready && s_axis_word.tlast |=> !s_axis_tready
   ) else $error("s_axis_tready high in the cycle after a tlast transfer");

   // Stalled head word and tuser hold
   for (genvar q = 0; q < NUM_QUEUES; q++) begin : g_queue
      a_head_stable: assert property (
         @(posedge axi_aclk) disable iff (!axi_resetn)
         m_axis_tvalid[q] && !m_axis_tready[q] |=>
            $stable(m_axis_word[q]) && $stable(m_axis_tuser[q])
      ) else $error("queue %0d output changed while stalled", q);
   end

   a_quiet_in_reset: assert property (
      @(posedge axi_aclk) !axi_resetn |=> m_axis_tvalid == '0 && !s_axis_tready
   ) else $error("tvalid or s_axis_tready high during reset");

endmodule

bind output_queues output_queues_properties i_output_queues_properties (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .s_axis_word   (s_axis_word),
   .s_axis_tvalid (s_axis_tvalid),
   .s_axis_tready (s_axis_tready),
   .m_axis_word   (m_axis_word),
   .m_axis_tuser  (m_axis_tuser),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready)
);

// File: tb/output_queues_tb.sv
// Output queue testbench: stimulus, queue model, scoreboard, timeout and final report

`timescale 1ns/1ps

module output_queues_tb import oq_pkg::*; ();

   // 4 unicast, 7 CPU or multicast, 2 empty, 8 stalled and 40 random packets
   localparam int NUM_PKTS    = 61;
   localparam int CYCLE_LIMIT = 40 * NUM_PKTS + 200;

   typedef struct packed {
      axis_word_t word;
      user_t      user;
   } beat_t;

   logic        axi_aclk;
   logic        axi_resetn;
   axis_word_t  s_axis_word;
   user_t       s_axis_tuser;
   logic        s_axis_tvalid;
   logic        s_axis_tready;
   axis_word_t  m_axis_word  [NUM_QUEUES];
   user_t       m_axis_tuser [NUM_QUEUES];
   queue_mask_t m_axis_tvalid;
   queue_mask_t m_axis_tready;

   // Queue model: expected beats and occupancy of both FIFOs
   beat_t       exp_q    [NUM_QUEUES][$];
   int          data_occ [NUM_QUEUES] = '{default: 0};
   int          meta_occ [NUM_QUEUES] = '{default: 0};
   logic        in_pkt   [NUM_QUEUES] = '{default: 1'b0};

   int          seed       = 77;
   int          errors     = 0;
   int          cycles     = 0;
   int          sent       = 0;
   int          drops      = 0;
   logic        hold       = 1'b0;
   logic        rand_ready = 1'b0;
   queue_mask_t stall      = '0;

   tb_clock_gen i_tb_clock_gen (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn)
   );

   output_queues i_output_queues (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_word   (s_axis_word),
      .s_axis_tuser  (s_axis_tuser),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_word   (m_axis_word),
      .m_axis_tuser  (m_axis_tuser),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   ////////////////////
   // Reference model
   ////////////////////

   // Even bits pick ports 0 to 3, any odd bit the CPU queue
   function automatic queue_mask_t dest_mask(input user_t u);
      logic [7:0] d;
      d = u[DST_POS +: 8];
      return {|(d & 8'haa), d[6], d[4], d[2], d[0]};
   endfunction

   // Free space for a longest packet and two metadata entries
   function automatic logic has_room(input int q);
      return (2 ** DATA_DEPTH_BITS - data_occ[q] >= MAX_PKT_WORDS) &&
             (2 ** META_DEPTH_BITS - meta_occ[q] >= 2);
   endfunction

   function automatic int rand_len();
      logic [31:0] r;
      r = $random(seed);
      return 1 + int'(r % MAX_PKT_WORDS);
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
      if (got !== expected) begin
         errors++;
         $display("error at %0t: %s = %0h, expected %0h", $time, name, got, expected);
      end
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   task automatic apply_ready();
      int r;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         r = $random(seed);
         m_axis_tready[q] = !(hold || stall[q]) && (!rand_ready || r[4]);
      end
   endtask

   task automatic tick();
      @(negedge axi_aclk);
      apply_ready();
   endtask

   task automatic send_packet(input logic [7:0] dst_bits, input int len);
      beat_t       pkt [MAX_PKT_WORDS];
      user_t       user;
      queue_mask_t mask;
      logic [31:0] r;
      logic        accept;
      logic        done;
      // Quiet outputs for 3 cycles so the registered room flags settle
      hold = 1'b1;
      apply_ready();
      repeat (3) tick();
      user = $random(seed);
      user[DST_POS +: 8] = dst_bits;
      for (int i = 0; i < len; i++) begin
         r = $random(seed);
         pkt[i].user       = user;
         pkt[i].word.tdata = $random(seed);
         pkt[i].word.tlast = (i == len - 1);
         pkt[i].word.tstrb = {STRB_WIDTH{1'b1}};
         if (i == len - 1) begin
            pkt[i].word.tstrb = {STRB_WIDTH{1'b1}} >> r[1:0];
         end
      end
      mask   = dest_mask(user);
      accept = 1'b1;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         accept = accept & (!mask[q] || has_room(q));
      end
      sent++;
      if (accept) begin
         for (int q = 0; q < NUM_QUEUES; q++) begin
            if (mask[q]) begin
               data_occ[q] += len;
               meta_occ[q]++;
               for (int i = 0; i < len; i++) begin
                  exp_q[q].push_back(pkt[i]);
               end
            end
         end
      end else begin
         drops++;
      end
      hold = 1'b0;
      apply_ready();
      for (int i = 0; i < len; i++) begin
         s_axis_word   = pkt[i].word;
         s_axis_tuser  = user;
         s_axis_tvalid = 1'b1;
         done          = 1'b0;
         while (!done) begin
            @(posedge axi_aclk);
            done = s_axis_tready;
            tick();
         end
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic wait_drained();
      logic busy;
      busy = 1'b1;
      while (busy) begin
         tick();
         busy = (m_axis_tvalid != '0);
         for (int q = 0; q < NUM_QUEUES; q++) begin
            busy = busy | (exp_q[q].size() != 0);
         end
      end
   endtask

   ////////////////////
   // Scoreboard
   ////////////////////

   always @(posedge axi_aclk) begin
      beat_t b;
      for (int q = 0; q < NUM_QUEUES; q++) begin
         if (axi_resetn && m_axis_tvalid[q] && m_axis_tready[q]) begin
            if (exp_q[q].size() == 0) begin
               errors++;
               $display("Queue %0d sent a beat that no accepted packet explains", q);
            end else begin
               b = exp_q[q].pop_front();
               check_value($sformatf("m_axis_word[%0d].tdata", q),
                           64'(m_axis_word[q].tdata), 64'(b.word.tdata));
               check_value($sformatf("m_axis_word[%0d].tstrb", q),
                           64'(m_axis_word[q].tstrb), 64'(b.word.tstrb));
               check_value($sformatf("m_axis_word[%0d].tlast", q),
                           64'(m_axis_word[q].tlast), 64'(b.word.tlast));
               check_value($sformatf("m_axis_tuser[%0d]", q),
                           64'(m_axis_tuser[q]), 64'(b.user));
               data_occ[q]--;
               // Metadata entry leaves with the first beat
               if (!in_pkt[q]) begin
                  meta_occ[q]--;
               end
               in_pkt[q] = !b.word.tlast;
            end
         end
      end
   end

   always @(posedge axi_aclk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Errors: %0d, packets sent: %0d, dropped: %0d", errors, sent, drops);
         $display("Testbench failed");
         $finish;
      end
   end

   initial begin
      logic [7:0] d;
      logic [7:0] d2;
      s_axis_word   = '0;
      s_axis_tuser  = '0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = '0;

      // Outputs and input ready stay low after reset
      @(posedge axi_resetn);
      repeat (4) begin
         tick();
         check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'(0));
         check_value("s_axis_tready", 64'(s_axis_tready), 64'(0));
      end

      for (int q = 0; q < 4; q++) begin
         send_packet(8'(1 << (2 * q)), rand_len());
      end
      // Each odd bit alone, then multicast
      for (int q = 0; q < 4; q++) begin
         send_packet(8'(2 << (2 * q)), rand_len());
      end
      send_packet(8'h05, rand_len());
      send_packet(8'h94, rand_len());
      send_packet(8'hff, rand_len());
      send_packet(8'h00, rand_len());
      send_packet(8'h00, rand_len());
      wait_drained();

      // Queue 2 stalled while queue 0 keeps flowing
      stall = 5'b00100;
      for (int i = 0; i < 8; i++) begin
         send_packet((i % 3 == 2) ? 8'h01 : 8'h10, rand_len());
      end
      // Queue 0 empties with queue 2 still stalled
      for (int i = 0; i < 2 * MAX_PKT_WORDS && exp_q[0].size() != 0; i++) begin
         tick();
      end
      if (exp_q[0].size() != 0) begin
         errors++;
         $display("Queue 0 did not drain while queue 2 was stalled");
      end
      stall = '0;
      wait_drained();

      // Random traffic under random back-pressure
      rand_ready = 1'b1;
      for (int i = 0; i < 40; i++) begin
         d  = 8'($random(seed));
         d2 = 8'($random(seed));
         send_packet(d & d2, rand_len());
      end
      rand_ready = 1'b0;
      wait_drained();
      repeat (3) tick();
      check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'(0));

      $display("Errors: %0d, packets sent: %0d, dropped: %0d", errors, sent, drops);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: tb/tb_clock_gen.sv
// Testbench clock and reset generator

`timescale 1ns/1ps

module tb_clock_gen (
   output logic axi_aclk,
   output logic axi_resetn
);

   // 40 ns period
   initial begin
      axi_aclk = 1'b0;
      forever #20 axi_aclk = ~axi_aclk;
   end

   // Reset for 4 cycles, released on a falling edge
   initial begin
      axi_resetn = 1'b0;
      repeat (4) @(posedge axi_aclk);
      @(negedge axi_aclk);
      axi_resetn = 1'b1;
   end

endmodule
